/* rtl/debug_params.svh */
`ifndef DEBUG_PARAMS_SVH
`define DEBUG_PARAMS_SVH

// width of pc, instruction and write-back words
`define DBG_DATA_WIDTH 32

// clk cycles per serial bit at 100 MHz and 115200 baud
`define DBG_CLKS_PER_BIT 868

// data bits per serial frame
`define DBG_UART_BITS 8

// bytes per data word
`define DBG_WORD_BYTES (`DBG_DATA_WIDTH / 8)

// opcode byte plus pc, instruction and result
`define DBG_SNAPSHOT_BYTES (3 * `DBG_WORD_BYTES + 1)

`endif

/* rtl/uart_pkg.sv */
`include "debug_params.svh"

package uart_pkg;

    // one serial payload
    typedef logic [`DBG_UART_BITS-1:0] uart_byte_t;

    // receiver states
    typedef enum logic [1:0] {
        RX_IDLE,    // waiting for a falling edge
        RX_START,   // checking the start bit at mid-bit
        RX_DATA,    // sampling data bits
        RX_STOP     // waiting for mid stop bit
    } rx_state_e;

    // transmitter states
    typedef enum logic {
        TX_IDLE,    // line held high
        TX_SEND     // frame on the line
    } tx_state_e;

endpackage

/* rtl/debug_pkg.sv */
`include "debug_params.svh"

package debug_pkg;

    // protocol opcodes
    typedef enum logic [7:0] {
        OP_SIGNAL = 8'h01,  // snapshot follows, to host
        OP_OK     = 8'h02,  // ping answer, to host
        OP_PING   = 8'h03,
        OP_PAUSE  = 8'h04,
        OP_RESUME = 8'h05,  // followed by 4 breakpoint bytes
        OP_NEXT   = 8'h06   // single step
    } dbg_op_e;

    // receive side of the controller
    typedef enum logic [1:0] {
        CMD_OPCODE,         // waiting for an opcode
        CMD_BREAKPOINT,     // collecting breakpoint bytes
        CMD_STEP            // core released for this cycle
    } cmd_state_e;

    // transmit side of the controller
    typedef enum logic [1:0] {
        RESP_IDLE,
        RESP_SNAPSHOT,      // streaming snapshot bytes
        RESP_PING           // sending ok
    } resp_state_e;

    // signals observed on the core
    typedef struct packed {
        logic [`DBG_DATA_WIDTH-1:0] pc;
        logic [`DBG_DATA_WIDTH-1:0] pc_next;
        logic [`DBG_DATA_WIDTH-1:0] instruction;
        logic [`DBG_DATA_WIDTH-1:0] wb_result;
    } core_probe_t;

endpackage

/* rtl/uart_receiver.sv */
`timescale 1ns/1ns
`include "debug_params.svh"

module uart_receiver import uart_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       rx,
    output uart_byte_t rx_byte,
    output logic       rx_valid
);

    localparam int CLKS      = `DBG_CLKS_PER_BIT;
    localparam int UART_BITS = `DBG_UART_BITS;
    localparam int CNT_W     = $clog2(CLKS);
    localparam int BIT_W     = $clog2(UART_BITS);

    localparam logic [CNT_W-1:0] FULL_LAST = CNT_W'(CLKS - 1);
    localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(CLKS / 2 - 1);
    localparam logic [BIT_W-1:0] BIT_LAST  = BIT_W'(UART_BITS - 1);

    logic             rx_meta;
    logic             rx_sync;
    logic             rx_prev;
    rx_state_e        state;
    logic [CNT_W-1:0] cnt;
    logic [BIT_W-1:0] bit_idx;
    uart_byte_t       shift;

    // two-flop synchronizer plus one stage for edge detection
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;                        // line idles high
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= RX_IDLE;
            cnt      <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                RX_IDLE: begin
                    cnt     <= '0;
                    bit_idx <= '0;
                    if (rx_prev && !rx_sync) begin
                        state <= RX_START;          // falling edge
                    end
                end
                RX_START: begin
                    if (cnt == HALF_LAST) begin
                        cnt   <= '0;
                        state <= rx_sync ? RX_IDLE : RX_DATA;   // high means a glitch
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (cnt == FULL_LAST) begin
                        cnt <= '0;
                        if (bit_idx == BIT_LAST) begin
                            state <= RX_STOP;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RX_STOP: begin
                    if (cnt == FULL_LAST) begin
                        cnt      <= '0;
                        state    <= RX_IDLE;
                        rx_valid <= rx_sync;        // drop frames with a bad stop bit
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == RX_DATA && cnt == FULL_LAST) begin
            shift <= {rx_sync, shift[UART_BITS-1:1]};   // lsb arrives first
        end
        if (state == RX_STOP && cnt == FULL_LAST && rx_sync) begin
            rx_byte <= shift;                       // held until the next frame
        end
    end

endmodule

/* rtl/uart_transmitter.sv */
`timescale 1ns/1ns
`include "debug_params.svh"

module uart_transmitter import uart_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  uart_byte_t tx_byte,
    input  logic       tx_start,
    output logic       tx,
    output logic       tx_busy,
    output logic       tx_done
);

    localparam int CLKS       = `DBG_CLKS_PER_BIT;
    localparam int UART_BITS  = `DBG_UART_BITS;
    localparam int FRAME_BITS = UART_BITS + 2;
    localparam int CNT_W      = $clog2(CLKS);
    localparam int IDX_W      = $clog2(FRAME_BITS);

    localparam logic [CNT_W-1:0] FULL_LAST = CNT_W'(CLKS - 1);
    localparam logic [IDX_W-1:0] IDX_LAST  = IDX_W'(FRAME_BITS - 1);

    tx_state_e        state;
    logic [CNT_W-1:0] cnt;
    logic [IDX_W-1:0] bit_idx;
    logic [UART_BITS:0] shreg;                      // data and stop bit, start bit driven directly

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= TX_IDLE;
            cnt     <= '0;
            bit_idx <= '0;
            tx      <= 1'b1;
            tx_done <= 1'b0;
        end else begin
            tx_done <= 1'b0;
            case (state)
                TX_IDLE: begin
                    tx <= 1'b1;
                    if (tx_start) begin
                        state   <= TX_SEND;
                        cnt     <= '0;
                        bit_idx <= '0;
                        tx      <= 1'b0;            // start bit
                    end
                end
                TX_SEND: begin
                    if (cnt == FULL_LAST) begin
                        cnt <= '0;
                        if (bit_idx == IDX_LAST) begin
                            state   <= TX_IDLE;     // end of stop bit
                            tx      <= 1'b1;
                            tx_done <= 1'b1;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            tx      <= shreg[0];
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == TX_IDLE && tx_start) begin
            shreg <= {1'b1, tx_byte};
        end else if (state == TX_SEND && cnt == FULL_LAST) begin
            shreg <= {1'b1, shreg[UART_BITS:1]};
        end
    end

    assign tx_busy = (state == TX_SEND);

endmodule

/* rtl/debug_controller.sv */
`timescale 1ns/1ns
`include "debug_params.svh"

module debug_controller import uart_pkg::*, debug_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  uart_byte_t  rx_byte,
    input  logic        rx_valid,
    input  core_probe_t probe,
    input  logic        tx_busy,
    input  logic        tx_done,
    output uart_byte_t  tx_byte,
    output logic        tx_start,
    output logic        debug_pause
);

    localparam int DATA_W     = `DBG_DATA_WIDTH;
    localparam int BYTE_W     = `DBG_UART_BITS;
    localparam int WORD_BYTES = `DBG_WORD_BYTES;
    localparam int SNAP_BYTES = `DBG_SNAPSHOT_BYTES;
    localparam int BUF_W      = DATA_W - BYTE_W;
    localparam int SNAP_W     = (SNAP_BYTES - 1) * BYTE_W;
    localparam int BP_IDX_W   = $clog2(WORD_BYTES);
    localparam int SNAP_CNT_W = $clog2(SNAP_BYTES);

    localparam logic [BP_IDX_W-1:0]   BP_LAST   = BP_IDX_W'(WORD_BYTES - 1);
    localparam logic [SNAP_CNT_W-1:0] SNAP_LAST = SNAP_CNT_W'(SNAP_BYTES - 1);

    cmd_state_e              cmd_state;
    resp_state_e             resp_state;
    logic [DATA_W-1:0]       breakpoint;
    logic [BUF_W-1:0]        bp_buf;            // lower breakpoint bytes so far
    logic [BP_IDX_W-1:0]     bp_idx;
    logic [SNAP_W-1:0]       snap_data;         // pc, instruction, result still to send
    logic [SNAP_CNT_W-1:0]   snap_cnt;
    logic                    stop_pending;      // core stopped while a response was going out

    logic opcode_ready;
    logic cmd_ping;
    logic cmd_pause;
    logic resp_free;
    logic pause_go;
    logic bp_hit;
    logic step_end;
    logic core_stop;
    logic snap_go;
    logic ok_go;
    logic next_go;

    assign opcode_ready = rx_valid && (cmd_state == CMD_OPCODE);
    assign cmd_ping     = opcode_ready && (rx_byte == uart_byte_t'(OP_PING));
    assign cmd_pause    = opcode_ready && (rx_byte == uart_byte_t'(OP_PAUSE));
    assign resp_free    = (resp_state == RESP_IDLE) && !tx_busy;
    assign pause_go     = cmd_pause && resp_free;   // ignored while answering
    assign bp_hit       = !debug_pause && (probe.pc_next == breakpoint);
    assign step_end     = (cmd_state == CMD_STEP);
    assign core_stop    = bp_hit || step_end;

    assign snap_go = resp_free && (core_stop || stop_pending || pause_go);
    assign ok_go   = resp_free && cmd_ping && !snap_go;
    assign next_go = (resp_state == RESP_SNAPSHOT) && tx_done && (snap_cnt != SNAP_LAST);

    // command side
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cmd_state   <= CMD_OPCODE;
            breakpoint  <= '0;
            bp_idx      <= '0;
            debug_pause <= 1'b1;                    // core starts paused
        end else begin
            case (cmd_state)
                CMD_OPCODE: begin
                    if (rx_valid) begin
                        case (rx_byte)
                            OP_RESUME: begin
                                debug_pause <= 1'b1;
                                bp_idx      <= '0;
                                cmd_state   <= CMD_BREAKPOINT;
                            end
                            OP_NEXT: begin
                                debug_pause <= 1'b0;    // released for one cycle
                                cmd_state   <= CMD_STEP;
                            end
                            default: cmd_state <= CMD_OPCODE;
                        endcase
                    end
                end
                CMD_BREAKPOINT: begin
                    if (rx_valid) begin
                        if (bp_idx == BP_LAST) begin
                            breakpoint  <= {rx_byte, bp_buf};
                            debug_pause <= 1'b0;    // run until pc_next hits
                            cmd_state   <= CMD_OPCODE;
                        end else begin
                            bp_idx <= bp_idx + 1'b1;
                        end
                    end
                end
                CMD_STEP:  cmd_state <= CMD_OPCODE;
                default:   cmd_state <= CMD_OPCODE;
            endcase
            if (pause_go || core_stop) begin
                debug_pause <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_state == CMD_BREAKPOINT && rx_valid) begin
            bp_buf <= {rx_byte, bp_buf[BUF_W-1:BYTE_W]};    // lsb first
        end
    end

    // response side
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resp_state   <= RESP_IDLE;
            snap_cnt     <= '0;
            stop_pending <= 1'b0;
            tx_start     <= 1'b0;
        end else begin
            tx_start <= snap_go || ok_go || next_go;
            if (snap_go) begin
                stop_pending <= 1'b0;
            end else if (core_stop) begin
                stop_pending <= 1'b1;
            end
            case (resp_state)
                RESP_IDLE: begin
                    if (snap_go) begin
                        resp_state <= RESP_SNAPSHOT;
                        snap_cnt   <= '0;
                    end else if (ok_go) begin
                        resp_state <= RESP_PING;
                    end
                end
                RESP_SNAPSHOT: begin
                    if (tx_done) begin
                        if (snap_cnt == SNAP_LAST) begin
                            resp_state <= RESP_IDLE;
                        end else begin
                            snap_cnt <= snap_cnt + 1'b1;
                        end
                    end
                end
                RESP_PING: begin
                    if (tx_done) begin
                        resp_state <= RESP_IDLE;
                    end
                end
                default: resp_state <= RESP_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (snap_go) begin
            snap_data <= {probe.wb_result, probe.instruction, probe.pc};
            tx_byte   <= uart_byte_t'(OP_SIGNAL);
        end else if (ok_go) begin
            tx_byte <= uart_byte_t'(OP_OK);
        end else if (next_go) begin
            tx_byte   <= snap_data[BYTE_W-1:0];
            snap_data <= snap_data >> BYTE_W;
        end
    end

endmodule

/* rtl/debug_unit.sv */
`timescale 1ns/1ns

module debug_unit import uart_pkg::*, debug_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        uart_rx,
    input  core_probe_t probe,
    output logic        uart_tx,
    output logic        debug_pause     // to the hazard unit
);

    uart_byte_t rx_byte;
    logic       rx_valid;
    uart_byte_t tx_byte;
    logic       tx_start;
    logic       tx_busy;
    logic       tx_done;

    uart_receiver rx_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx       (uart_rx),
        .rx_byte  (rx_byte),
        .rx_valid (rx_valid)
    );

    uart_transmitter tx_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .tx_byte  (tx_byte),
        .tx_start (tx_start),
        .tx       (uart_tx),
        .tx_busy  (tx_busy),
        .tx_done  (tx_done)
    );

    debug_controller ctrl_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .rx_byte     (rx_byte),
        .rx_valid    (rx_valid),
        .probe       (probe),
        .tx_busy     (tx_busy),
        .tx_done     (tx_done),
        .tx_byte     (tx_byte),
        .tx_start    (tx_start),
        .debug_pause (debug_pause)
    );

endmodule

/* testbench/debug_unit_asserts.sv */
`timescale 1ns/1ns

module debug_unit_asserts import debug_pkg::*; (
    input logic       clk,
    input logic       rst_n,
    input logic       uart_tx,
    input logic       tx_busy,
    input logic       tx_start,
    input logic       rx_valid,
    input logic       debug_pause,
    input cmd_state_e cmd_state
);

    // line must idle high between frames
    tx_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
        !tx_busy |-> uart_tx)
        else $error("uart_tx low while the transmitter is idle");

    tx_start_free: assert property (@(posedge clk) disable iff (!rst_n)
        tx_start |-> !tx_busy)
        else $error("tx_start raised while the transmitter is busy");

    rx_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        rx_valid |=> !rx_valid)
        else $error("rx_valid held for more than one cycle");

    // core released for a single cycle only
    step_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        (cmd_state == CMD_STEP) |-> !debug_pause ##1 debug_pause)
        else $error("debug_pause not low for exactly one cycle in step mode");

endmodule

/* testbench/debug_unit_tb.sv */
`timescale 1ns/1ns
`include "debug_params.svh"

module debug_unit_tb import uart_pkg::*, debug_pkg::*; ();

    localparam int CLK_PERIOD   = 10;
    localparam int CLKS         = `DBG_CLKS_PER_BIT;
    localparam int FRAME_CYCLES = 10 * CLKS;
    localparam int SNAP_BYTES   = `DBG_SNAPSHOT_BYTES;
    localparam int NUM_CMDS     = 11;               // command bytes plus the glitch
    localparam int NUM_SNAPS    = 3;
    localparam int WATCHDOG_NS  =
        (NUM_CMDS + NUM_SNAPS * SNAP_BYTES) * 20 * FRAME_CYCLES * CLK_PERIOD;

    typedef logic [7:0] byte_q_t[$];

    logic        clk = 1'b0;
    logic        rst_n;
    logic        uart_rx;
    core_probe_t probe;
    logic        uart_tx;
    logic        debug_pause;

    byte_q_t     exp_q;                             // bytes the host should see
    byte_q_t     got_q;                             // bytes decoded from uart_tx
    int          seed = 32'h0145b0a0;
    int          low_cycles = 0;
    int          last_low_len = 0;
    logic [`DBG_DATA_WIDTH-1:0] bp;

    debug_unit dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .uart_rx     (uart_rx),
        .probe       (probe),
        .uart_tx     (uart_tx),
        .debug_pause (debug_pause)
    );

    bind debug_unit debug_unit_asserts asserts_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .uart_tx     (uart_tx),
        .tx_busy     (tx_busy),
        .tx_start    (tx_start),
        .rx_valid    (rx_valid),
        .debug_pause (debug_pause),
        .cmd_state   (ctrl_i.cmd_state)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "run aborted");
    endtask

    task automatic compare_values(input string what, input logic [31:0] got,
                                  input logic [31:0] want);
        if (got !== want) begin
            abort_run($sformatf("ERROR at %0t ns: %s is %h, expected %h",
                                $time, what, got, want));
        end
    endtask

    // start bit, 8 data bits lsb first, stop bit
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        @(negedge clk);
        for (int i = 0; i < 10; i++) begin
            uart_rx = frame[i];
            repeat (CLKS) @(negedge clk);
        end
    endtask

    task automatic new_probe();
        probe.pc          = $random(seed);
        probe.pc_next     = $random(seed);
        probe.instruction = $random(seed);
        probe.wb_result   = $random(seed);
        if (probe.pc_next == bp) begin
            probe.pc_next = ~bp;                    // stay clear of the breakpoint
        end
    endtask

    // bytes the host sees after a command or a breakpoint hit
    function automatic byte_q_t expected_bytes(input logic [7:0] cmd, input core_probe_t p);
        byte_q_t                    q;
        logic [`DBG_DATA_WIDTH-1:0] words [3];
        words[0] = p.pc;
        words[1] = p.instruction;
        words[2] = p.wb_result;
        case (cmd)
            OP_PING: q.push_back(8'h02);
            OP_PAUSE, OP_RESUME, OP_NEXT: begin
                q.push_back(8'h01);
                for (int w = 0; w < 3; w++) begin
                    for (int i = 0; i < `DBG_WORD_BYTES; i++) begin
                        q.push_back(words[w][8*i +: 8]);    // lsb first
                    end
                end
            end
            default: q.delete();
        endcase
        return q;
    endfunction

    task automatic expect_response(input logic [7:0] cmd);
        byte_q_t resp;
        resp = expected_bytes(cmd, probe);
        foreach (resp[i]) begin
            exp_q.push_back(resp[i]);
        end
    endtask

    task automatic wait_responses();
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (2 * FRAME_CYCLES) @(negedge clk);   // room for stray bytes
    endtask

    task automatic wait_pause(input logic level, input int max_cycles);
        int n;
        n = 0;
        while (debug_pause !== level) begin
            @(negedge clk);
            n++;
            if (n > max_cycles) begin
                abort_run($sformatf("debug_pause did not go to %b within %0d cycles",
                                    level, max_cycles));
            end
        end
    endtask

    // uart_tx sampled at mid-bit
    initial begin : decode_tx
        logic [7:0] b;
        forever begin
            @(negedge uart_tx);
            repeat (CLKS / 2) @(negedge clk);
            compare_values("start bit", 32'(uart_tx), 32'd0);
            for (int i = 0; i < 8; i++) begin
                repeat (CLKS) @(negedge clk);
                b[i] = uart_tx;
            end
            repeat (CLKS) @(negedge clk);
            compare_values("stop bit", 32'(uart_tx), 32'd1);
            got_q.push_back(b);
        end
    end

    initial begin : compare_responses
        logic [7:0] got;
        logic [7:0] want;
        forever begin
            @(negedge clk);
            while (got_q.size() != 0) begin
                got = got_q.pop_front();
                if (exp_q.size() == 0) begin
                    abort_run($sformatf("byte %h came out of uart_tx with no response due",
                                        got));
                end
                want = exp_q.pop_front();
                compare_values("response byte", 32'(got), 32'(want));
            end
        end
    end

    // length of the last low stretch of debug_pause
    always @(negedge clk) begin
        if (rst_n && !debug_pause) begin
            low_cycles++;
        end else if (low_cycles != 0) begin
            last_low_len = low_cycles;
            low_cycles   = 0;
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        abort_run($sformatf("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS));
    end

    initial begin : run_tests
        rst_n   = 1'b0;
        uart_rx = 1'b1;
        probe   = '0;
        bp      = '0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        repeat (2 * FRAME_CYCLES) @(negedge clk);   // quiet after reset
        compare_values("debug_pause after reset", 32'(debug_pause), 32'd1);
        compare_values("uart_tx after reset", 32'(uart_tx), 32'd1);

        expect_response(OP_PING);
        send_byte(OP_PING);
        wait_responses();

        new_probe();                                // held through the snapshot
        expect_response(OP_PAUSE);
        send_byte(OP_PAUSE);
        wait_responses();
        compare_values("debug_pause after pause", 32'(debug_pause), 32'd1);

        bp = $random(seed);
        new_probe();
        send_byte(OP_RESUME);
        for (int i = 0; i < `DBG_WORD_BYTES; i++) begin
            send_byte(bp[8*i +: 8]);
        end
        wait_pause(1'b0, 2 * CLKS);
        for (int i = 0; i < 16; i++) begin
            @(negedge clk);
            compare_values("debug_pause while running", 32'(debug_pause), 32'd0);
            probe.pc_next = $random(seed);
            if (probe.pc_next == bp) begin
                probe.pc_next = ~bp;
            end
        end
        @(negedge clk);
        new_probe();
        probe.pc_next = bp;                         // hit on the next edge
        expect_response(OP_RESUME);
        @(negedge clk);
        compare_values("debug_pause after breakpoint hit", 32'(debug_pause), 32'd1);
        wait_responses();

        new_probe();
        last_low_len = 0;
        expect_response(OP_NEXT);
        send_byte(OP_NEXT);
        wait_responses();
        compare_values("debug_pause low cycles on step", 32'(last_low_len), 32'd1);
        compare_values("debug_pause after step", 32'(debug_pause), 32'd1);

        send_byte(8'h07);                           // unknown opcode
        repeat (2 * FRAME_CYCLES) @(negedge clk);
        compare_values("debug_pause after unknown opcode", 32'(debug_pause), 32'd1);

        @(negedge clk);
        uart_rx = 1'b0;                             // glitch under half a bit
        repeat (CLKS / 4) @(negedge clk);
        uart_rx = 1'b1;
        repeat (2 * CLKS) @(negedge clk);           // a frame started by the glitch would swallow the ping
        expect_response(OP_PING);
        send_byte(OP_PING);
        wait_responses();

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+rtl
rtl/uart_pkg.sv
rtl/debug_pkg.sv
rtl/uart_receiver.sv
rtl/uart_transmitter.sv
rtl/debug_controller.sv
rtl/debug_unit.sv
testbench/debug_unit_asserts.sv
testbench/debug_unit_tb.sv

/* Makefile */
VERILATOR := verilator
FLAGS     := --timing --assert --timescale 1ns/1ns
TOP       := debug_unit_tb
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_TEXT := Simulation completed successfully

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
